//--- src/wb_pkg.sv
package wb_pkg;

   localparam int ADR_W      = 32;       // Byte address width
   localparam int DAT_W      = 32;       // One bus word
   localparam int SEL_W      = DAT_W / 8; // One select per byte lane
   localparam int WORD_SHIFT = 2;        // Byte to word address shift

   localparam int MEM_WORDS  = 1024;     // SRAM depth
   localparam int MEM_AW     = 10;       // Word index width, adr[11:2]

   // Requester order on the arbiter
   localparam int N_MASTERS  = 3;        // 0 fetch, 1 data, 2 debug

   typedef logic [ADR_W-1:0]  adr_t;     // Bus byte address
   typedef logic [DAT_W-1:0]  dat_t;     // Bus data word
   typedef logic [SEL_W-1:0]  sel_t;     // Byte lane selects
   typedef logic [1:0]        mst_idx_t; // Arbiter grant index
   typedef logic [MEM_AW-1:0] mem_idx_t; // SRAM word index

endpackage

//--- src/core_pkg.sv
package core_pkg;

   // Instruction field positions
   localparam int OPC_LSB = 28;          // Opcode in [31:28]
   localparam int OPC_W   = 4;
   localparam int RD_LSB  = 24;          // rd in [26:24]
   localparam int RS_LSB  = 20;          // rs in [22:20]
   localparam int REG_W   = 3;           // Eight registers
   localparam int IMM_W   = 16;          // Signed imm in [15:0]
   localparam int N_REGS  = 1 << REG_W;

   typedef logic [wb_pkg::DAT_W-1:0] insn_t;    // One instruction word
   typedef logic [REG_W-1:0]         reg_idx_t; // Register number

   typedef enum logic [OPC_W-1:0] {
      OP_LI   = 4'd1,                    // rd = sext(imm)
      OP_ADD  = 4'd2,                    // rd = rd + rs
      OP_XOR  = 4'd3,                    // rd = rd ^ rs
      OP_LD   = 4'd4,                    // rd = mem[rs + imm*4]
      OP_ST   = 4'd5,                    // mem[rs + imm*4] = rd
      OP_BNZ  = 4'd6,                    // Branch if rd nonzero
      OP_HALT = 4'd15                    // Stop for good
   } opcode_e;

   typedef enum logic [1:0] {
      S_FETCH,                           // Instruction bus cycle
      S_EXEC,                            // Decode and ALU
      S_MEM,                             // Data bus cycle
      S_HALT                             // Parked after HALT
   } core_state_e;

endpackage

//--- src/wb_if.sv
`timescale 1ns/1ps

interface wb_if;

   logic             cyc;                // Cycle valid
   logic             stb;                // Strobe, raised with cyc
   logic             we;                 // Write transfer
   wb_pkg::adr_t     adr;                // Byte address
   wb_pkg::sel_t     sel;                // Byte lane selects
   wb_pkg::dat_t     dat_w;              // Master to slave data
   wb_pkg::dat_t     dat_r;              // Slave to master data
   logic             ack;                // One-cycle termination

   modport master (
      output cyc, stb, we, adr, sel, dat_w,
      input  dat_r, ack
   );

   modport slave (
      input  cyc, stb, we, adr, sel, dat_w,
      output dat_r, ack
   );

endinterface

//--- src/cpu_core.sv
`timescale 1ns/1ps

module cpu_core (
   input  logic                clk_i,
   input  logic                arst_n_i,
   input  logic                stall_i,        // Holds off the next fetch
   wb_if.master                ibus,           // Instruction fetch master
   wb_if.master                dbus,           // Load/store master
   output logic                halted_o,
   output logic                trace_valid_o,  // One pulse per retired insn
   output wb_pkg::adr_t        trace_pc_o,
   output core_pkg::insn_t     trace_insn_o,
   output logic                trace_wben_o,
   output core_pkg::reg_idx_t  trace_wbreg_o,
   output wb_pkg::dat_t        trace_wbdata_o
);

   core_pkg::core_state_e state_q;
   wb_pkg::adr_t          pc_q;
   core_pkg::insn_t       insn_q;         // Latched on fetch ack
   logic                  icyc_q;         // Fetch cycle in flight
   logic                  dcyc_q;         // Load/store cycle in flight
   wb_pkg::dat_t          rf [core_pkg::N_REGS];

   core_pkg::opcode_e     opc;
   core_pkg::reg_idx_t    rd;
   core_pkg::reg_idx_t    rs;
   wb_pkg::dat_t          rd_val;
   wb_pkg::dat_t          rs_val;
   wb_pkg::dat_t          imm_sx;
   wb_pkg::adr_t          ea;             // Load/store effective address
   wb_pkg::adr_t          pc_nxt;
   wb_pkg::dat_t          wb_data;
   logic                  wb_en;
   logic                  is_mem;
   logic                  retire;

   // Field decode of the latched word
   assign opc    = core_pkg::opcode_e'(insn_q[core_pkg::OPC_LSB +: core_pkg::OPC_W]);
   assign rd     = insn_q[core_pkg::RD_LSB +: core_pkg::REG_W];
   assign rs     = insn_q[core_pkg::RS_LSB +: core_pkg::REG_W];
   assign imm_sx = {{(wb_pkg::DAT_W - core_pkg::IMM_W){insn_q[core_pkg::IMM_W-1]}},
                    insn_q[core_pkg::IMM_W-1:0]};

   assign rd_val = (rd == '0) ? '0 : rf[rd];  // r0 reads zero
   assign rs_val = (rs == '0) ? '0 : rf[rs];
   assign ea     = rs_val + (imm_sx << wb_pkg::WORD_SHIFT);
   assign is_mem = (opc == core_pkg::OP_LD) || (opc == core_pkg::OP_ST);

   // Taken branch adds imm words, else next word
   assign pc_nxt = (opc == core_pkg::OP_BNZ && rd_val != '0) ?
                   pc_q + (imm_sx << wb_pkg::WORD_SHIFT) :
                   pc_q + (wb_pkg::adr_t'(1) << wb_pkg::WORD_SHIFT);

   // Result and writeback enable
   always_comb begin
      case (opc)
         core_pkg::OP_LI:  wb_data = imm_sx;
         core_pkg::OP_ADD: wb_data = rd_val + rs_val;
         core_pkg::OP_XOR: wb_data = rd_val ^ rs_val;
         core_pkg::OP_LD:  wb_data = dbus.dat_r;   // Valid in ack cycle
         default:          wb_data = '0;
      endcase
      wb_en = (opc == core_pkg::OP_LI || opc == core_pkg::OP_ADD ||
               opc == core_pkg::OP_XOR || opc == core_pkg::OP_LD) && (rd != '0);
   end

   // Non-memory insns retire in EXEC, loads and stores on data ack
   assign retire = (state_q == core_pkg::S_EXEC && !is_mem) ||
                   (state_q == core_pkg::S_MEM && dbus.ack);

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q <= core_pkg::S_FETCH;
         pc_q    <= '0;
         icyc_q  <= 1'b0;
         dcyc_q  <= 1'b0;
      end else begin
         case (state_q)
            core_pkg::S_FETCH: begin
               if (!icyc_q) begin
                  icyc_q <= !stall_i;            // Stall only checked here
               end else if (ibus.ack) begin
                  icyc_q  <= 1'b0;
                  state_q <= core_pkg::S_EXEC;
               end
            end
            core_pkg::S_EXEC: begin
               if (is_mem) begin
                  dcyc_q  <= 1'b1;
                  state_q <= core_pkg::S_MEM;
               end else if (opc == core_pkg::OP_HALT) begin
                  state_q <= core_pkg::S_HALT;   // pc stays on the HALT
               end else begin
                  pc_q    <= pc_nxt;
                  state_q <= core_pkg::S_FETCH;
               end
            end
            core_pkg::S_MEM: begin
               if (dbus.ack) begin
                  dcyc_q  <= 1'b0;
                  pc_q    <= pc_nxt;
                  state_q <= core_pkg::S_FETCH;
               end
            end
            default: state_q <= core_pkg::S_HALT;  // Parked
         endcase
      end
   end

   // Instruction word and register file
   always_ff @(posedge clk_i) begin
      if (state_q == core_pkg::S_FETCH && icyc_q && ibus.ack)
         insn_q <= ibus.dat_r;
      if (retire && wb_en)
         rf[rd] <= wb_data;
   end

   // Trace record, one cycle after retirement
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i)
         trace_valid_o <= 1'b0;
      else
         trace_valid_o <= retire;
   end

   always_ff @(posedge clk_i) begin
      if (retire) begin
         trace_pc_o     <= pc_q;
         trace_insn_o   <= insn_q;
         trace_wben_o   <= wb_en;
         trace_wbreg_o  <= wb_en ? rd : '0;       // Zero when nothing written
         trace_wbdata_o <= wb_en ? wb_data : '0;
      end
   end

   assign halted_o = (state_q == core_pkg::S_HALT);

   // Fetch master, read only
   assign ibus.cyc   = icyc_q;
   assign ibus.stb   = icyc_q;
   assign ibus.we    = 1'b0;
   assign ibus.adr   = pc_q;
   assign ibus.sel   = '1;
   assign ibus.dat_w = '0;

   // Data master, request held stable by insn_q in S_MEM
   assign dbus.cyc   = dcyc_q;
   assign dbus.stb   = dcyc_q;
   assign dbus.we    = (opc == core_pkg::OP_ST);
   assign dbus.adr   = ea;
   assign dbus.sel   = '1;                     // Full words only
   assign dbus.dat_w = rd_val;

endmodule

//--- src/wb_arbiter.sv
`timescale 1ns/1ps

module wb_arbiter (
   input  logic  clk_i,
   input  logic  arst_n_i,
   wb_if.slave   m0,                     // Instruction fetch
   wb_if.slave   m1,                     // Core data
   wb_if.slave   m2,                     // Debug bridge
   wb_if.master  s                       // Shared slave side
);

   logic [wb_pkg::N_MASTERS-1:0] req;
   wb_pkg::mst_idx_t             grant_q;   // Last or current grantee
   wb_pkg::mst_idx_t             grant_nxt;
   logic                         found;
   logic                         busy_q;    // Cycle owned by grant_q
   logic                         sel_cyc;
   logic                         sel_stb;

   assign req = {m2.cyc, m1.cyc, m0.cyc};

   // Round-robin search starting after the last grantee
   always_comb begin
      grant_nxt = grant_q;
      found     = 1'b0;
      for (int i = 1; i <= wb_pkg::N_MASTERS; i++) begin
         if (!found && req[(int'(grant_q) + i) % wb_pkg::N_MASTERS]) begin
            grant_nxt = wb_pkg::mst_idx_t'((int'(grant_q) + i) % wb_pkg::N_MASTERS);
            found     = 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         busy_q  <= 1'b0;
         grant_q <= wb_pkg::mst_idx_t'(wb_pkg::N_MASTERS - 1); // First search hits m0
      end else if (!busy_q) begin
         if (found) begin                  // Grant only when idle
            busy_q  <= 1'b1;
            grant_q <= grant_nxt;
         end
      end else if (!sel_cyc) begin
         busy_q <= 1'b0;                   // Grantee dropped cyc
      end
   end

   // Request mux
   always_comb begin
      case (grant_q)
         2'd0: begin
            sel_cyc = m0.cyc;
            sel_stb = m0.stb;
            s.we    = m0.we;
            s.adr   = m0.adr;
            s.sel   = m0.sel;
            s.dat_w = m0.dat_w;
         end
         2'd1: begin
            sel_cyc = m1.cyc;
            sel_stb = m1.stb;
            s.we    = m1.we;
            s.adr   = m1.adr;
            s.sel   = m1.sel;
            s.dat_w = m1.dat_w;
         end
         default: begin
            sel_cyc = m2.cyc;
            sel_stb = m2.stb;
            s.we    = m2.we;
            s.adr   = m2.adr;
            s.sel   = m2.sel;
            s.dat_w = m2.dat_w;
         end
      endcase
   end

   assign s.cyc = busy_q & sel_cyc;
   assign s.stb = busy_q & sel_stb;

   // Termination to the grantee only
   assign m0.ack   = busy_q && (grant_q == 2'd0) && s.ack;
   assign m1.ack   = busy_q && (grant_q == 2'd1) && s.ack;
   assign m2.ack   = busy_q && (grant_q == 2'd2) && s.ack;
   assign m0.dat_r = (grant_q == 2'd0) ? s.dat_r : '0;
   assign m1.dat_r = (grant_q == 2'd1) ? s.dat_r : '0;
   assign m2.dat_r = (grant_q == 2'd2) ? s.dat_r : '0;

endmodule

//--- src/wb_sram.sv
`timescale 1ns/1ps

module wb_sram (
   input  logic  clk_i,
   input  logic  arst_n_i,
   wb_if.slave   bus
);

   wb_pkg::dat_t     mem [wb_pkg::MEM_WORDS];
   wb_pkg::mem_idx_t idx;
   logic             access;             // New request this cycle

   // Word index from adr[11:2], upper bits wrap
   assign idx    = bus.adr[wb_pkg::MEM_AW + wb_pkg::WORD_SHIFT - 1 : wb_pkg::WORD_SHIFT];
   assign access = bus.cyc && bus.stb && !bus.ack;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i)
         bus.ack <= 1'b0;
      else
         bus.ack <= access;                // Single pulse per request
   end

   // Storage and read port
   always_ff @(posedge clk_i) begin
      if (access) begin
         if (bus.we) begin
            for (int b = 0; b < wb_pkg::SEL_W; b++) begin
               if (bus.sel[b])
                  mem[idx][8*b +: 8] <= bus.dat_w[8*b +: 8];  // Per byte lane
            end
         end
         bus.dat_r <= mem[idx];            // Valid with ack
      end
   end

endmodule

//--- src/dbg_bridge.sv
`timescale 1ns/1ps

module dbg_bridge (
   input  logic          clk_i,
   input  logic          arst_n_i,
   input  logic          dbg_stb_i,      // One-cycle request strobe
   input  logic          dbg_we_i,
   input  wb_pkg::adr_t  dbg_adr_i,
   input  wb_pkg::dat_t  dbg_dat_i,
   output wb_pkg::dat_t  dbg_dat_o,      // Held after a read
   output logic          dbg_ack_o,      // One pulse per transfer
   wb_if.master          bus
);

   logic         pending_q;              // Transfer in flight
   logic         we_q;
   wb_pkg::adr_t adr_q;
   wb_pkg::dat_t dat_q;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         pending_q <= 1'b0;
         dbg_ack_o <= 1'b0;
      end else begin
         dbg_ack_o <= pending_q && bus.ack;
         if (!pending_q)
            pending_q <= dbg_stb_i;        // Strobes while busy are dropped
         else if (bus.ack)
            pending_q <= 1'b0;
      end
   end

   // Request capture and read data hold
   always_ff @(posedge clk_i) begin
      if (!pending_q && dbg_stb_i) begin
         we_q  <= dbg_we_i;
         adr_q <= dbg_adr_i;
         dat_q <= dbg_dat_i;
      end
      if (pending_q && bus.ack && !we_q)
         dbg_dat_o <= bus.dat_r;
   end

   assign bus.cyc   = pending_q;
   assign bus.stb   = pending_q;
   assign bus.we    = we_q;
   assign bus.adr   = adr_q;
   assign bus.sel   = '1;                  // Whole words
   assign bus.dat_w = dat_q;

endmodule

//--- src/or1k_tile.sv
`timescale 1ns/1ps

module or1k_tile (
   input  logic                clk_i,
   input  logic                arst_n_i,
   input  logic                dbg_stb_i,       // Debug address/data strobe
   input  logic                dbg_we_i,        // Debug write enable
   input  wb_pkg::adr_t        dbg_adr_i,
   input  wb_pkg::dat_t        dbg_dat_i,
   output wb_pkg::dat_t        dbg_dat_o,
   output logic                dbg_ack_o,       // Debug transfer done
   input  logic                dbg_stall_i,     // Holds the core before fetch
   output logic                core_halted_o,
   output logic                trace_valid_o,
   output wb_pkg::adr_t        trace_pc_o,
   output core_pkg::insn_t     trace_insn_o,
   output logic                trace_wben_o,
   output core_pkg::reg_idx_t  trace_wbreg_o,
   output wb_pkg::dat_t        trace_wbdata_o
);

   wb_if ibus ();                        // Core fetch
   wb_if dbus ();                        // Core load/store
   wb_if dbgbus ();                      // Debug bridge
   wb_if mem_bus ();                     // Arbiter to SRAM

   cpu_core u_cpu (
      .clk_i          (clk_i),
      .arst_n_i       (arst_n_i),
      .stall_i        (dbg_stall_i),
      .ibus           (ibus.master),
      .dbus           (dbus.master),
      .halted_o       (core_halted_o),
      .trace_valid_o  (trace_valid_o),
      .trace_pc_o     (trace_pc_o),
      .trace_insn_o   (trace_insn_o),
      .trace_wben_o   (trace_wben_o),
      .trace_wbreg_o  (trace_wbreg_o),
      .trace_wbdata_o (trace_wbdata_o)
   );

   dbg_bridge u_dbg (
      .clk_i     (clk_i),
      .arst_n_i  (arst_n_i),
      .dbg_stb_i (dbg_stb_i),
      .dbg_we_i  (dbg_we_i),
      .dbg_adr_i (dbg_adr_i),
      .dbg_dat_i (dbg_dat_i),
      .dbg_dat_o (dbg_dat_o),
      .dbg_ack_o (dbg_ack_o),
      .bus       (dbgbus.master)
   );

   // Master order sets arbiter index
   wb_arbiter u_arb (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .m0       (ibus.slave),
      .m1       (dbus.slave),
      .m2       (dbgbus.slave),
      .s        (mem_bus.master)
   );

   wb_sram u_mem (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .bus      (mem_bus.slave)
   );

endmodule

//--- sim/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen (
   input  logic rst_req_i,               // Rising edge starts a new reset
   output logic clk_o,
   output logic arst_n_o
);

   initial clk_o = 1'b0;
   always #5 clk_o = ~clk_o;             // 10 ns period

   initial begin
      arst_n_o = 1'b0;                   // Power-on reset
      forever begin
         repeat (5) @(posedge clk_o);    // Held for 5 cycles
         @(negedge clk_o);
         arst_n_o = 1'b1;                // Release away from the active edge
         @(posedge rst_req_i);
         arst_n_o = 1'b0;
      end
   end

endmodule

//--- sim/tb_or1k_tile.sv
`timescale 1ns/1ps

module tb_or1k_tile;

   localparam int TMO_CYCLES = 2000;     // Limit for any single wait

   typedef struct packed {
      wb_pkg::adr_t       pc;
      core_pkg::insn_t    insn;
      logic               wben;
      core_pkg::reg_idx_t wbreg;
      wb_pkg::dat_t       wbdata;
   } trace_rec_t;

   logic               clk;
   logic               arst_n;
   logic               rst_req;          // Asks the clock module for a reset
   logic               dbg_stb;
   logic               dbg_we;
   wb_pkg::adr_t       dbg_adr;
   wb_pkg::dat_t       dbg_wdat;
   wb_pkg::dat_t       dbg_rdat;
   logic               dbg_ack;
   logic               dbg_stall;
   logic               halted;
   logic               trace_valid;
   wb_pkg::adr_t       trace_pc;
   core_pkg::insn_t    trace_insn;
   logic               trace_wben;
   core_pkg::reg_idx_t trace_wbreg;
   wb_pkg::dat_t       trace_wbdata;

   integer          seed = 80966;
   int              mismatches;
   int              other_errs;
   int              trace_cnt;           // Trace pulses seen so far
   int              ack_cnt;             // Debug acks seen so far
   int              xfer_cnt;            // Debug strobes issued so far
   string           cur_test;            // Program now running
   wb_pkg::dat_t    model_mem [wb_pkg::MEM_WORDS];
   wb_pkg::dat_t    model_rf [core_pkg::N_REGS];
   wb_pkg::dat_t    seen_rf [core_pkg::N_REGS];  // Register values as reported by the trace
   trace_rec_t      exp_q [$];           // Predicted retirements in order
   core_pkg::insn_t prog [$];

   tb_clkgen u_clk (
      .rst_req_i (rst_req),
      .clk_o     (clk),
      .arst_n_o  (arst_n)
   );

   or1k_tile DUT (
      .clk_i          (clk),
      .arst_n_i       (arst_n),
      .dbg_stb_i      (dbg_stb),
      .dbg_we_i       (dbg_we),
      .dbg_adr_i      (dbg_adr),
      .dbg_dat_i      (dbg_wdat),
      .dbg_dat_o      (dbg_rdat),
      .dbg_ack_o      (dbg_ack),
      .dbg_stall_i    (dbg_stall),
      .core_halted_o  (halted),
      .trace_valid_o  (trace_valid),
      .trace_pc_o     (trace_pc),
      .trace_insn_o   (trace_insn),
      .trace_wben_o   (trace_wben),
      .trace_wbreg_o  (trace_wbreg),
      .trace_wbdata_o (trace_wbdata)
   );

   function automatic int urand(input int n);  // Uniform 0 to n-1
      urand = int'($unsigned($random(seed)) % $unsigned(n));
   endfunction

   function automatic core_pkg::insn_t make_insn(input logic [3:0] op, input int rd,
                                                 input int rs, input logic [15:0] imm);
      make_insn = {op, 1'b0, 3'(rd), 1'b0, 3'(rs), 4'b0000, imm};
   endfunction

   task automatic check(input string name, input logic [31:0] exp_v,
                        input logic [31:0] act_v);
      if (exp_v !== act_v) begin
         mismatches++;
         $display("FAIL %s: expected %h, actual %h", name, exp_v, act_v);
      end
   endtask

   task automatic report_error(input string what);
      other_errs++;
      $display("ERROR: %s", what);
   endtask

   task automatic finish_run;
      $display("Summary: %0d value mismatches, %0d other errors", mismatches, other_errs);
      if (mismatches == 0 && other_errs == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   endtask

   task automatic timeout_stop(input string what);
      report_error({"timed out waiting for ", what});
      finish_run();
   endtask

   // Trace and debug ack monitor sampled on the falling edge
   always @(negedge clk) begin : monitor
      trace_rec_t rec;
      if (arst_n && dbg_ack)
         ack_cnt++;
      if (arst_n && trace_valid) begin
         trace_cnt++;
         if (exp_q.size() == 0) begin
            report_error({cur_test, ": trace pulse with no instruction left to retire"});
         end else begin
            rec = exp_q.pop_front();
            check({cur_test, " trace pc"}, rec.pc, trace_pc);
            check({cur_test, " trace insn"}, rec.insn, trace_insn);
            check({cur_test, " trace wben"}, 32'(rec.wben), 32'(trace_wben));
            if (rec.wben) begin          // Writeback fields only mean something here
               check({cur_test, " trace wbreg"}, 32'(rec.wbreg), 32'(trace_wbreg));
               check({cur_test, " trace wbdata"}, rec.wbdata, trace_wbdata);
            end
         end
         if (trace_wben) begin
            if (trace_wbreg == '0)
               report_error({cur_test, ": register 0 was reported as written"});
            seen_rf[trace_wbreg] = trace_wbdata;
         end
      end
   end

   task automatic wait_reset_release;
      int n;
      n = 0;
      while (!arst_n && n < TMO_CYCLES) begin
         @(negedge clk);
         n++;
      end
      if (!arst_n)
         timeout_stop("reset release");
   endtask

   // One debug transfer with a one-cycle strobe
   task automatic dbg_xfer(input logic we, input int w, input wb_pkg::dat_t wdat,
                           output wb_pkg::dat_t rdat);
      int n;
      xfer_cnt++;
      @(negedge clk);
      dbg_stb  = 1'b1;
      dbg_we   = we;
      dbg_adr  = wb_pkg::adr_t'(w << 2);  // Word to byte address
      dbg_wdat = wdat;
      @(negedge clk);
      dbg_stb = 1'b0;
      n = 0;
      while (!dbg_ack && n < TMO_CYCLES) begin
         @(negedge clk);
         n++;
      end
      if (!dbg_ack)
         timeout_stop("debug acknowledge");
      rdat = dbg_rdat;
      @(negedge clk);
      if (ack_cnt != xfer_cnt)
         report_error("a debug strobe did not give exactly one acknowledge");
   endtask

   task automatic mem_write(input int w, input wb_pkg::dat_t d);
      wb_pkg::dat_t unused;
      dbg_xfer(1'b1, w, d, unused);
      model_mem[w] = d;
   endtask

   task automatic mem_read_check(input string name, input int w);
      wb_pkg::dat_t rd;
      dbg_xfer(1'b0, w, '0, rd);
      check(name, model_mem[w], rd);
   endtask

   // Instruction-set model running the loaded program from pc 0 to HALT
   task automatic iss_run;
      wb_pkg::adr_t    pc;
      wb_pkg::adr_t    ea;
      wb_pkg::adr_t    nxt;
      core_pkg::insn_t insn;
      wb_pkg::dat_t    imm;
      wb_pkg::dat_t    rdv;
      wb_pkg::dat_t    rsv;
      wb_pkg::dat_t    val;
      logic [2:0]      rd;
      logic [2:0]      rs;
      logic            wr;
      logic            done;
      trace_rec_t      rec;
      int              steps;
      pc    = '0;
      done  = 1'b0;
      steps = 0;
      while (!done && steps < 4000) begin
         insn = model_mem[pc[11:2]];
         rd   = insn[26:24];
         rs   = insn[22:20];
         imm  = {{16{insn[15]}}, insn[15:0]};
         rdv  = (rd == 3'd0) ? '0 : model_rf[rd];  // r0 reads zero
         rsv  = (rs == 3'd0) ? '0 : model_rf[rs];
         ea   = rsv + (imm << 2);
         nxt  = pc + 32'd4;
         wr   = 1'b0;
         val  = '0;
         case (insn[31:28])
            core_pkg::OP_LI: begin
               wr  = 1'b1;
               val = imm;
            end
            core_pkg::OP_ADD: begin
               wr  = 1'b1;
               val = rdv + rsv;
            end
            core_pkg::OP_XOR: begin
               wr  = 1'b1;
               val = rdv ^ rsv;
            end
            core_pkg::OP_LD: begin
               wr  = 1'b1;
               val = model_mem[ea[11:2]];
            end
            core_pkg::OP_ST:   model_mem[ea[11:2]] = rdv;
            core_pkg::OP_BNZ: begin
               if (rdv != '0)
                  nxt = pc + (imm << 2);
            end
            core_pkg::OP_HALT: done = 1'b1;
            default: ;                   // No-op
         endcase
         rec      = '0;
         rec.pc   = pc;
         rec.insn = insn;
         if (wr && rd != 3'd0) begin
            model_rf[rd] = val;
            rec.wben     = 1'b1;
            rec.wbreg    = rd;
            rec.wbdata   = val;
         end
         exp_q.push_back(rec);
         pc = nxt;
         steps++;
      end
      if (!done)
         report_error("model program never reached HALT");
   endtask

   task automatic gen_init_regs;         // Give r1 to r7 a known value
      for (int r = 1; r < core_pkg::N_REGS; r++)
         prog.push_back(make_insn(core_pkg::OP_LI, r, 0, 16'(urand(65536))));
   endtask

   task automatic gen_straight(input int n);
      logic [3:0] op;
      prog.delete();
      gen_init_regs();
      repeat (n) begin
         case (urand(3))
            0:       op = core_pkg::OP_LI;
            1:       op = core_pkg::OP_ADD;
            default: op = core_pkg::OP_XOR;
         endcase
         prog.push_back(make_insn(op, urand(8), urand(8), 16'(urand(65536))));
      end
      prog.push_back(make_insn(core_pkg::OP_HALT, 0, 0, 16'h0000));
   endtask

   // r7 holds the data base at word 512 and is never overwritten
   task automatic gen_ldst(input int n, input int span);
      prog.delete();
      gen_init_regs();
      prog.push_back(make_insn(core_pkg::OP_LI, 7, 0, 16'h0800));
      repeat (n) begin
         case (urand(4))
            0: prog.push_back(make_insn(core_pkg::OP_LD, urand(7), 7, 16'(urand(span))));
            1: prog.push_back(make_insn(core_pkg::OP_ST, urand(8), 7, 16'(urand(span))));
            2: prog.push_back(make_insn(core_pkg::OP_ADD, urand(7), urand(8), 16'h0000));
            default: prog.push_back(make_insn(core_pkg::OP_XOR, urand(7), urand(8), 16'h0000));
         endcase
      end
      prog.push_back(make_insn(core_pkg::OP_HALT, 0, 0, 16'h0000));
   endtask

   task automatic gen_loop(input int count);
      prog.delete();
      prog.push_back(make_insn(core_pkg::OP_LI, 1, 0, 16'(count)));  // Counter
      prog.push_back(make_insn(core_pkg::OP_LI, 2, 0, 16'hFFFF));    // Step of -1
      prog.push_back(make_insn(core_pkg::OP_ADD, 1, 2, 16'h0000));   // pc 8
      prog.push_back(make_insn(core_pkg::OP_BNZ, 1, 0, 16'hFFFF));   // Back to pc 8
      prog.push_back(make_insn(core_pkg::OP_HALT, 0, 0, 16'h0000));
   endtask

   // Full program run from reset to the quiet time after HALT
   task automatic run_program(input string name, input logic contend);
      int n;
      int base;
      cur_test = name;
      @(negedge clk);
      dbg_stall = 1'b1;
      rst_req   = 1'b1;
      @(negedge clk);
      rst_req = 1'b0;
      wait_reset_release();
      for (int i = 0; i < prog.size(); i++)
         mem_write(i, prog[i]);
      exp_q.delete();
      iss_run();
      base = trace_cnt;
      repeat (20) @(negedge clk);
      if (trace_cnt != base)
         report_error({name, ": trace pulse while the core was stalled"});
      dbg_stall = 1'b0;
      n = 0;
      while (!halted && n < TMO_CYCLES) begin
         if (contend)
            mem_read_check({name, " debug read"}, 768 + urand(256));  // Never stored
         else
            @(negedge clk);
         n++;
      end
      if (!halted)
         timeout_stop("core halt");
      @(negedge clk);                    // HALT record counted by now
      base = trace_cnt;
      repeat (50) @(negedge clk);
      check({name, " halted"}, 32'd1, 32'(halted));
      check({name, " records left"}, 32'd0, 32'(exp_q.size()));
      if (trace_cnt != base)
         report_error({name, ": trace pulse after HALT"});
      dbg_stall = 1'b1;
   endtask

   initial begin
      int w;
      dbg_stb    = 1'b0;
      dbg_we     = 1'b0;
      dbg_adr    = '0;
      dbg_wdat   = '0;
      dbg_stall  = 1'b1;                 // Core held from the start
      rst_req    = 1'b0;
      mismatches = 0;
      other_errs = 0;
      trace_cnt  = 0;
      ack_cnt    = 0;
      xfer_cnt   = 0;
      cur_test   = "debug";
      wait_reset_release();

      // Debug access over the data region
      for (w = 512; w < wb_pkg::MEM_WORDS; w++)
         mem_write(w, $random(seed));
      repeat (32) begin
         w = 512 + urand(512);
         mem_write(w, $random(seed));
         mem_read_check("debug write readback", w);
      end
      repeat (64)
         mem_read_check("debug read", 512 + urand(512));

      repeat (3) begin
         gen_straight(20);
         run_program("straight", 1'b0);
      end

      repeat (3) begin
         gen_ldst(24, 512);
         run_program("ldst", 1'b0);
         for (w = 512; w < wb_pkg::MEM_WORDS; w++)
            mem_read_check("ldst final memory", w);
      end

      repeat (3) begin
         gen_loop(1 + urand(8));
         seen_rf[1] = '1;
         run_program("loop", 1'b0);
         check("loop counter", 32'd0, seen_rf[1]);
      end

      repeat (2) begin                   // Stores stay in words 512 to 767
         gen_ldst(24, 256);
         run_program("contention", 1'b1);
      end

      finish_run();
   end

endmodule

//--- vlog.f
src/wb_pkg.sv
src/core_pkg.sv
src/wb_if.sv
src/cpu_core.sv
src/wb_arbiter.sv
src/wb_sram.sv
src/dbg_bridge.sv
src/or1k_tile.sv
sim/tb_clkgen.sv
sim/tb_or1k_tile.sv

//--- Makefile
TOP := tb_or1k_tile

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): vlog.f $(wildcard src/*.sv sim/*.sv)
	verilator --binary --timing --timescale 1ns/1ps -f vlog.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f vlog.f --top-module $(TOP)

clean:
	rm -rf obj_dir
